/* compile.f */
kronos_types.sv
kronos_pipe_if.sv
kronos_if.sv
kronos_id.sv
kronos_ex.sv
kronos_wb.sv
kronos_core.sv
tb_clkgen.sv
tb_kronos_core.sv

/* kronos_core.sv */
// Kronos 4-stage RV32I core

`timescale 1ns/1ps

module kronos_core #(
    parameter kronos_types::word_t BOOT_ADDR = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    output kronos_types::word_t    instr_addr,
    input  kronos_types::word_t    instr_data,
    output logic                   instr_req,
    input  logic                   instr_gnt,
    // Retire trace
    output logic                   regwr_en,
    output kronos_types::reg_sel_t regwr_sel,
    output kronos_types::word_t    regwr_data
);
    import kronos_types::*;

    fetch_if  fetch ();
    decode_if decode ();

    // Redirect from write-back
    logic     branch;
    word_t    branch_target;

    // Destination of the instruction in execute
    reg_sel_t ex_rd;
    logic     ex_wr;

    // Execute register
    word_t    ex_result;
    reg_sel_t ex_dest;
    logic     ex_regwr;
    logic     ex_branch_req;
    word_t    ex_target;
    logic     ex_vld;

    // ====================
    // Fetch
    // ====================
    kronos_if #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_if (
        .clk           (clk),
        .reset         (reset),
        .instr_addr    (instr_addr),
        .instr_data    (instr_data),
        .instr_req     (instr_req),
        .instr_gnt     (instr_gnt),
        .fetch         (fetch.source),
        .branch        (branch),
        .branch_target (branch_target)
    );

    // ====================
    // Decode
    // ====================
    kronos_id u_id (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch.sink),
        .decode     (decode.source),
        .ex_rd      (ex_rd),
        .ex_wr      (ex_wr),
        .regwr_en   (regwr_en),
        .regwr_sel  (regwr_sel),
        .regwr_data (regwr_data),
        .branch     (branch)
    );

    // ====================
    // Execute
    // ====================
    kronos_ex u_ex (
        .clk        (clk),
        .reset      (reset),
        .decode     (decode.sink),
        .ex_rd      (ex_rd),
        .ex_wr      (ex_wr),
        .result     (ex_result),
        .rd         (ex_dest),
        .regwr      (ex_regwr),
        .branch_req (ex_branch_req),
        .target     (ex_target),
        .vld        (ex_vld),
        .branch     (branch)
    );

    // ====================
    // Write-back
    // ====================
    kronos_wb u_wb (
        .clk           (clk),
        .reset         (reset),
        .result        (ex_result),
        .rd            (ex_dest),
        .regwr         (ex_regwr),
        .branch_req    (ex_branch_req),
        .target        (ex_target),
        .vld           (ex_vld),
        .regwr_en      (regwr_en),
        .regwr_sel     (regwr_sel),
        .regwr_data    (regwr_data),
        .branch        (branch),
        .branch_target (branch_target)
    );

endmodule

/* kronos_ex.sv */
// Kronos execute stage

`timescale 1ns/1ps

module kronos_ex (
    input  logic                   clk,
    input  logic                   reset,
    decode_if.sink                 decode,
    output kronos_types::reg_sel_t ex_rd,
    output logic                   ex_wr,
    output kronos_types::word_t    result,
    output kronos_types::reg_sel_t rd,
    output logic                   regwr,
    output logic                   branch_req,
    output kronos_types::word_t    target,
    output logic                   vld,
    input  logic                   branch
);
    import kronos_types::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t ex_result;
    word_t ex_target;
    logic  writes_rd;
    logic  cond;
    logic  taken;

    assign op_a = decode.rs1_data;
    assign op_b = (decode.op_class == CLS_ALU_REG) ? decode.rs2_data : decode.imm;

    // ====================
    // ALU
    // ====================
    always_comb begin
        case (decode.funct3)
            // SUB only for register form, ADDI has imm bits there
            3'b000: alu_out = (decode.alt && decode.op_class == CLS_ALU_REG)
                            ? op_a - op_b : op_a + op_b;
            3'b001: alu_out = op_a << op_b[4:0];
            3'b010: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            3'b011: alu_out = {31'b0, op_a < op_b};
            3'b100: alu_out = op_a ^ op_b;
            3'b101: alu_out = decode.alt ? word_t'($signed(op_a) >>> op_b[4:0])
                                         : op_a >> op_b[4:0];
            3'b110: alu_out = op_a | op_b;
            default: alu_out = op_a & op_b;
        endcase
    end

    always_comb begin
        case (decode.op_class)
            CLS_LUI:               ex_result = decode.imm;
            CLS_AUIPC:             ex_result = decode.pc + decode.imm;
            CLS_JAL, CLS_JALR:     ex_result = decode.pc + 32'd4;
            default:               ex_result = alu_out;
        endcase
    end

    // ====================
    // Branch unit
    // ====================
    always_comb begin
        case (decode.funct3)
            3'b000:  cond = decode.rs1_data == decode.rs2_data;
            3'b001:  cond = decode.rs1_data != decode.rs2_data;
            3'b100:  cond = $signed(decode.rs1_data) < $signed(decode.rs2_data);
            3'b101:  cond = $signed(decode.rs1_data) >= $signed(decode.rs2_data);
            3'b110:  cond = decode.rs1_data < decode.rs2_data;
            3'b111:  cond = decode.rs1_data >= decode.rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign taken = (decode.op_class == CLS_BRANCH && cond)
                || decode.op_class == CLS_JAL || decode.op_class == CLS_JALR;

    // JALR clears bit 0 of the sum
    assign ex_target = (decode.op_class == CLS_JALR)
                     ? ((decode.rs1_data + decode.imm) & ~32'd1)
                     : decode.pc + decode.imm;

    assign writes_rd = (decode.op_class != CLS_BRANCH) && (decode.op_class != CLS_NOP);

    // Hazard info for decode
    assign ex_rd = decode.rd;
    assign ex_wr = decode.vld && writes_rd;

    // ====================
    // Execute register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= 1'b0;
        end else begin
            vld <= decode.vld && !branch;
        end
    end

    always_ff @(posedge clk) begin
        result     <= ex_result;
        rd         <= decode.rd;
        regwr      <= writes_rd;
        branch_req <= taken;
        target     <= ex_target;
    end

endmodule

/* kronos_id.sv */
// Kronos decode stage

`timescale 1ns/1ps

module kronos_id (
    input  logic                   clk,
    input  logic                   reset,
    fetch_if.sink                  fetch,
    decode_if.source               decode,
    input  kronos_types::reg_sel_t ex_rd,
    input  logic                   ex_wr,
    input  logic                   regwr_en,
    input  kronos_types::reg_sel_t regwr_sel,
    input  kronos_types::word_t    regwr_data,
    input  logic                   branch
);
    import kronos_types::*;

    // x1..x31, x0 is hardwired
    word_t     regs [31:1];

    logic [6:0] opcode;
    reg_sel_t   rs1;
    reg_sel_t   rs2;
    op_class_t  op_class;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       use_rs1;
    logic       use_rs2;
    logic       stall;

    assign opcode = fetch.instr[6:0];
    assign rs1    = fetch.instr[19:15];
    assign rs2    = fetch.instr[24:20];

    // ====================
    // Register file
    // ====================
    always_ff @(posedge clk) begin
        if (regwr_en && regwr_sel != '0) begin
            regs[regwr_sel] <= regwr_data;
        end
    end

    // Same-cycle write passes straight through
    function automatic word_t read_reg(input reg_sel_t sel);
        if (sel == '0) begin
            return '0;
        end else if (regwr_en && regwr_sel == sel) begin
            return regwr_data;
        end else begin
            return regs[sel];
        end
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

    // ====================
    // Decode
    // ====================
    always_comb begin
        op_class = CLS_NOP;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        // I-type by default
        imm      = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
        case (opcode)
            OPC_OP: begin
                op_class = CLS_ALU_REG;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OPC_OP_IMM: begin
                op_class = CLS_ALU_IMM;
                use_rs1  = 1'b1;
            end
            OPC_LUI: begin
                op_class = CLS_LUI;
                imm      = {fetch.instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                op_class = CLS_AUIPC;
                imm      = {fetch.instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                op_class = CLS_JAL;
                imm      = {{11{fetch.instr[31]}}, fetch.instr[31], fetch.instr[19:12],
                            fetch.instr[20], fetch.instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                op_class = CLS_JALR;
                use_rs1  = 1'b1;
            end
            OPC_BRANCH: begin
                op_class = CLS_BRANCH;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                imm      = {{19{fetch.instr[31]}}, fetch.instr[31], fetch.instr[7],
                            fetch.instr[30:25], fetch.instr[11:8], 1'b0};
            end
            default: op_class = CLS_NOP;
        endcase
    end

    // RAW on the instruction now in execute, no forwarding
    assign stall = fetch.vld && ex_wr && (ex_rd != '0)
                && ((use_rs1 && rs1 == ex_rd) || (use_rs2 && rs2 == ex_rd));

    assign fetch.rdy = !stall;

    // ====================
    // Decode register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            decode.vld <= 1'b0;
        end else begin
            // Bubble on stall, flush on redirect
            decode.vld <= fetch.vld && !stall && !branch;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.vld && !stall) begin
            decode.pc       <= fetch.pc;
            decode.rs1_data <= rs1_data;
            decode.rs2_data <= rs2_data;
            decode.imm      <= imm;
            decode.rd       <= fetch.instr[11:7];
            decode.funct3   <= fetch.instr[14:12];
            decode.alt      <= fetch.instr[30];
            decode.op_class <= op_class;
        end
    end

endmodule

/* kronos_if.sv */
// Kronos fetch stage

`timescale 1ns/1ps

module kronos_if #(
    parameter kronos_types::word_t BOOT_ADDR = '0
) (
    input  logic                clk,
    input  logic                reset,
    output kronos_types::word_t instr_addr,
    input  kronos_types::word_t instr_data,
    output logic                instr_req,
    input  logic                instr_gnt,
    fetch_if.source             fetch,
    input  logic                branch,
    input  kronos_types::word_t branch_target
);
    import kronos_types::*;

    fetch_state_t state;
    // Address of the pending or next request
    word_t        pc;
    // Target parked while a stale grant is awaited
    word_t        redirect_pc;
    logic         granted;
    logic         out_free;

    assign granted  = (state == REQ) && instr_gnt;
    // Output empty, or drained at this edge
    assign out_free = !fetch.vld || fetch.rdy;

    // Bus held stable until grant
    assign instr_req  = (state != IDLE);
    assign instr_addr = pc;

    // ====================
    // Request FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= BOOT_ADDR;
        end else begin
            case (state)
                IDLE: begin
                    if (branch) begin
                        pc    <= branch_target;
                        state <= REQ;
                    end else if (out_free) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (branch) begin
                        // Grant now means the word is simply discarded
                        if (instr_gnt) begin
                            pc <= branch_target;
                        end else begin
                            state <= DROP;
                        end
                    end else if (instr_gnt) begin
                        pc    <= pc + 32'd4;
                        state <= IDLE;
                    end
                end
                DROP: begin
                    // Wait out the stale grant, then go to target
                    if (instr_gnt) begin
                        pc    <= redirect_pc;
                        state <= REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (branch) begin
            redirect_pc <= branch_target;
        end
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.vld <= 1'b0;
        end else if (branch) begin
            fetch.vld <= 1'b0;
        end else if (granted) begin
            fetch.vld <= 1'b1;
        end else if (fetch.rdy) begin
            fetch.vld <= 1'b0;
        end
    end

    // Only loaded in REQ, output is always free there
    always_ff @(posedge clk) begin
        if (granted) begin
            fetch.pc    <= pc;
            fetch.instr <= instr_data;
        end
    end

endmodule

/* kronos_pipe_if.sv */
// Kronos pipeline links

`timescale 1ns/1ps

// Fetch to decode, valid/ready
interface fetch_if;
    import kronos_types::*;

    word_t pc;
    word_t instr;
    logic  vld;
    // Low while decode stalls
    logic  rdy;

    modport source (
        output pc, instr, vld,
        input  rdy
    );

    modport sink (
        input  pc, instr, vld,
        output rdy
    );
endinterface

// Decode to execute, always accepted
interface decode_if;
    import kronos_types::*;

    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_sel_t  rd;
    funct3_t   funct3;
    // funct7 bit 5, selects SUB and SRA
    logic      alt;
    op_class_t op_class;
    logic      vld;

    modport source (output pc, rs1_data, rs2_data, imm, rd, funct3, alt, op_class, vld);
    modport sink   (input  pc, rs1_data, rs2_data, imm, rd, funct3, alt, op_class, vld);
endinterface

/* kronos_types.sv */
// Kronos shared types
// Widths, opcodes and decode classes

package kronos_types;

    // ====================
    // Widths
    // ====================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  op_class_t;

    // ====================
    // RV32I opcodes
    // ====================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ====================
    // Decoded classes
    // ====================
    localparam op_class_t CLS_ALU_REG = 3'd0;
    localparam op_class_t CLS_ALU_IMM = 3'd1;
    localparam op_class_t CLS_LUI     = 3'd2;
    localparam op_class_t CLS_AUIPC   = 3'd3;
    localparam op_class_t CLS_JAL     = 3'd4;
    localparam op_class_t CLS_JALR    = 3'd5;
    localparam op_class_t CLS_BRANCH  = 3'd6;
    // Anything unsupported retires silently
    localparam op_class_t CLS_NOP     = 3'd7;

    // Fetch FSM
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DROP
    } fetch_state_t;

endpackage

/* kronos_wb.sv */
// Kronos write-back stage

`timescale 1ns/1ps

module kronos_wb (
    input  logic                   clk,
    input  logic                   reset,
    input  kronos_types::word_t    result,
    input  kronos_types::reg_sel_t rd,
    input  logic                   regwr,
    input  logic                   branch_req,
    input  kronos_types::word_t    target,
    input  logic                   vld,
    output logic                   regwr_en,
    output kronos_types::reg_sel_t regwr_sel,
    output kronos_types::word_t    regwr_data,
    output logic                   branch,
    output kronos_types::word_t    branch_target
);

    // Set in the cycle after a redirect
    logic branch_done;

    // x0 writes never retire
    assign regwr_en   = vld && regwr && (rd != '0);
    assign regwr_sel  = rd;
    assign regwr_data = result;

    // One pulse per taken instruction
    assign branch        = vld && branch_req && !branch_done;
    assign branch_target = target;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_done <= 1'b0;
        end else begin
            branch_done <= branch;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the Kronos core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_kronos_core -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_kronos_core
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0

/* tb_clkgen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* tb_kronos_core.sv */
// Kronos core testbench

`timescale 1ns/1ps

module tb_kronos_core;

    localparam int OPC_LUI    = 'h37;
    localparam int OPC_AUIPC  = 'h17;
    localparam int OPC_OP_IMM = 'h13;
    localparam int OPC_JALR   = 'h67;
    // ADDI x0,x0,0
    localparam logic [31:0] NOP = 32'h0000_0013;
    // Quiet cycles after the last retire
    localparam int TAIL_CYCLES = 40;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr_data = NOP;
    logic        instr_req;
    logic        instr_gnt = 1'b0;
    logic        regwr_en;
    logic [4:0]  regwr_sel;
    logic [31:0] regwr_data;

    // Program words and expected retire stream
    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    logic [31:0] rng_state = 32'd40501;
    int          wait_left = 0;
    logic        busy = 1'b0;
    // Address of the request waiting for its grant
    logic [31:0] held_addr = '0;
    int          cycles = 0;

    tb_clkgen #(.PERIOD(100), .RESET_CYCLES(10)) clkgen (.clk(clk), .reset(reset));

    kronos_core #(.BOOT_ADDR(32'h0)) dut (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .instr_req  (instr_req),
        .instr_gnt  (instr_gnt),
        .regwr_en   (regwr_en),
        .regwr_sel  (regwr_sel),
        .regwr_data (regwr_data)
    );

    // ====================
    // Encoders
    // ====================
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] u_type(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // Program word plus its retire, none expected when rd is zero
    task automatic add_instr(input logic [31:0] word, input int rd, input logic [31:0] data);
        prog.push_back(word);
        if (rd != 0) begin
            exp_rd.push_back(rd[4:0]);
            exp_data.push_back(data);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // ====================
    // Instruction memory
    // ====================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= 0 && idx < prog.size()) begin
            return prog[idx];
        end
        return NOP;
    endfunction

    // Random 0..3 cycle grant latency per request
    always @(posedge clk) begin
        #1;
        instr_gnt = 1'b0;
        if (reset) begin
            busy = 1'b0;
        end else if (busy || instr_req) begin
            if (busy) begin
                // Pending request holds still until granted
                assert (instr_req)
                    else stop_with_failure("Instruction request withdrawn before its grant");
                assert (instr_addr == held_addr)
                    else stop_with_failure($sformatf(
                        "** Error: instr_addr expected %h got %h", held_addr, instr_addr));
            end else begin
                rng_state = lcg_next(rng_state);
                wait_left = int'((rng_state >> 16) & 32'd3);
                held_addr = instr_addr;
                busy      = 1'b1;
            end
            if (wait_left == 0) begin
                instr_gnt  = 1'b1;
                instr_data = fetch_word(instr_addr);
                busy       = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // Watchdog sized from the program length
    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= (prog.size() + 8) * 12) begin
                stop_with_failure($sformatf("Timeout after %0d cycles", cycles));
            end
        end
    end

    task automatic wait_retire();
        @(negedge clk);
        while (!regwr_en) @(negedge clk);
    endtask

    // ====================
    // Program and expected retires
    // ====================
    initial begin
        // Immediate ALU with LUI and AUIPC
        // Second word depends on the first
        add_instr(u_type(OPC_LUI, 1, 'h12345), 1, 32'h1234_5000);
        add_instr(i_type(OPC_OP_IMM, 0, 1, 1, 'h678), 1, 32'h1234_5678);
        add_instr(i_type(OPC_OP_IMM, 0, 2, 0, -5), 2, 32'hffff_fffb);
        add_instr(u_type(OPC_AUIPC, 3, 1), 3, 32'h0000_100c);
        add_instr(i_type(OPC_OP_IMM, 2, 4, 2, -4), 4, 32'h0000_0001);
        add_instr(i_type(OPC_OP_IMM, 3, 5, 2, 5), 5, 32'h0000_0000);
        add_instr(i_type(OPC_OP_IMM, 4, 6, 1, -1), 6, 32'hedcb_a987);
        add_instr(i_type(OPC_OP_IMM, 6, 7, 1, 'h0f0), 7, 32'h1234_56f8);
        add_instr(i_type(OPC_OP_IMM, 7, 8, 1, 'h7ff), 8, 32'h0000_0678);
        add_instr(i_type(OPC_OP_IMM, 1, 9, 2, 4), 9, 32'hffff_ffb0);
        add_instr(i_type(OPC_OP_IMM, 5, 10, 2, 28), 10, 32'h0000_000f);
        // SRAI carries funct7 bit 5 in the immediate
        add_instr(i_type(OPC_OP_IMM, 5, 11, 2, 'h401), 11, 32'hffff_fffd);
        // Register ALU
        add_instr(r_type('h20, 0, 12, 2, 1), 12, 32'hedcb_a983);
        add_instr(r_type(0, 0, 13, 1, 2), 13, 32'h1234_5673);
        add_instr(r_type(0, 1, 14, 1, 10), 14, 32'h2b3c_0000);
        add_instr(r_type(0, 2, 15, 2, 4), 15, 32'h0000_0001);
        add_instr(r_type(0, 3, 16, 2, 4), 16, 32'h0000_0000);
        add_instr(r_type(0, 4, 17, 1, 6), 17, 32'hffff_ffff);
        add_instr(r_type(0, 5, 18, 2, 4), 18, 32'h7fff_fffd);
        add_instr(r_type('h20, 5, 19, 2, 4), 19, 32'hffff_fffd);
        add_instr(r_type(0, 6, 20, 10, 4), 20, 32'h0000_000f);
        add_instr(r_type(0, 7, 21, 1, 6), 21, 32'h0000_0000);
        // Most negative word against zero
        add_instr(u_type(OPC_LUI, 22, 'h80000), 22, 32'h8000_0000);
        add_instr(r_type(0, 2, 23, 22, 0), 23, 32'h0000_0001);
        add_instr(r_type(0, 3, 24, 0, 22), 24, 32'h0000_0001);
        add_instr(r_type('h20, 5, 25, 22, 10), 25, 32'hffff_0000);
        // Silent x0 write followed by an x0 read
        add_instr(i_type(OPC_OP_IMM, 0, 0, 0, 123), 0, '0);
        add_instr(r_type(0, 0, 26, 0, 0), 26, 32'h0000_0000);
        // Taken branches skip the next word
        add_instr(b_type(0, 13, 13, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 1), 0, '0);
        add_instr(b_type(1, 1, 1, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 2), 27, 32'h0000_0002);
        add_instr(b_type(4, 2, 0, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 3), 0, '0);
        add_instr(b_type(7, 2, 0, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 4), 0, '0);
        add_instr(b_type(6, 2, 1, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 28, 0, 5), 28, 32'h0000_0005);
        add_instr(b_type(5, 2, 4, 8), 0, '0);
        // JAL and JALR, the JALR target has bit 0 set
        add_instr(j_type(29, 8), 29, 32'h0000_00a0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 6), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 31, 0, 'hb5), 31, 32'h0000_00b5);
        add_instr(i_type(OPC_JALR, 0, 30, 31, 0), 30, 32'h0000_00ac);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 7), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 27, 0, 8), 0, '0);
        add_instr(i_type(OPC_OP_IMM, 0, 28, 28, 1), 28, 32'h0000_0006);
        add_instr(r_type(0, 0, 27, 29, 30), 27, 32'h0000_014c);

        @(negedge reset);
        for (int i = 0; i < exp_rd.size(); i++) begin
            wait_retire();
            assert (regwr_sel == exp_rd[i])
                else stop_with_failure($sformatf(
                    "** Error: regwr_sel expected %h got %h (retire %0d)",
                    exp_rd[i], regwr_sel, i));
            assert (regwr_data == exp_data[i])
                else stop_with_failure($sformatf(
                    "** Error: regwr_data expected %h got %h (retire %0d)",
                    exp_data[i], regwr_data, i));
        end

        // Past the program only NOPs come back
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            assert (!regwr_en)
                else stop_with_failure($sformatf(
                    "Unexpected register write to x%0d after the last retire", regwr_sel));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
